// ==== testbench/qla_tests.txt ====
# columns: op arg1 arg2 arg3, all numbers hex
# W addr data err | R addr err data | F axis fb 0 | D axis value 0 | A cycles 0 amp_en
R 0011 0 00008000
W 0000 0000000f 0
R 0000 0 00000a0f
W 0001 00000001 0
R 0001 0 00000001
W 0021 00001234 0
D 2 00001234 0
R 0021 0 00001234
W 0021 00005555 0
W 0031 00003333 0
W 0011 00001111 0
W 0031 00003344 0
D 2 00005555 0
D 1 00001111 0
D 3 00003344 0
R 0031 0 00003344
W 0011 00008100 0
D 1 00008100 0
F 1 00008300 0
A 14 0 f
F 1 00008400 0
A a 0 e
R 0000 0 00000a1f
F 1 00008000 0
W 0000 0000010f 0
A 3 0 f
R 0000 0 00000a0f
R 0051 1 00000000
W 0051 00001234 1
R 0011 0 00008100
R 0001 0 00000001
A 3c 0 f

// ==== all.f ====
design/qla_pkg.sv
design/qla_reg_bridge.sv
design/qla_board_regs.sv
design/qla_dac_ctrl.sv
design/qla_safety_check.sv
design/qla_top.sv
testbench/qla_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the qla testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module qla_tb -f all.f -o qla_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/qla_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Test completed successfully$"; then
    exit 0
fi
exit 1

// ==== testbench/qla_tb.sv ====
// --------------------
// qla register top testbench
// runs the vector file over apb, drives feedback, checks dac frames and amp_en
// --------------------

`timescale 1ns/100ps
`default_nettype none

module qla_tb;

    localparam int TIMEOUT = 200;                   // cycles per wait

    logic                           sysclk;
    logic                           rst_n;
    logic [qla_pkg::ADDR_W-1:0]     paddr;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [qla_pkg::DATA_W-1:0]     pwdata;
    logic [qla_pkg::DATA_W-1:0]     prdata;
    logic                           pready;
    logic                           pslverr;
    logic [3:0]                     board_id;
    logic [qla_pkg::CUR_W-1:0]      cur_fb1;
    logic [qla_pkg::CUR_W-1:0]      cur_fb2;
    logic [qla_pkg::CUR_W-1:0]      cur_fb3;
    logic [qla_pkg::CUR_W-1:0]      cur_fb4;
    logic [qla_pkg::NUM_AXES-1:0]   amp_en;
    logic                           pwr_enable;
    logic                           dac_sclk;
    logic                           dac_mosi;
    logic                           dac_csel;

    int   error_count = 0;
    int   pass_count = 0;
    int   test_count = 0;
    logic test_bad;

    logic [qla_pkg::DAC_FRAME_W-1:0] frame_q[$];    // captured frames with oldest first
    logic [qla_pkg::DAC_FRAME_W-1:0] frame_shift;
    int   frame_bits = 0;

    qla_top u_qla_top (
        .sysclk(sysclk), .rst_n(rst_n),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .board_id(board_id),
        .cur_fb1(cur_fb1), .cur_fb2(cur_fb2), .cur_fb3(cur_fb3), .cur_fb4(cur_fb4),
        .amp_en(amp_en), .pwr_enable(pwr_enable),
        .dac_sclk(dac_sclk), .dac_mosi(dac_mosi), .dac_csel(dac_csel)
    );

    initial begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;                // 100 MHz
    end

    // --------------------
    // dac monitor samples mosi on rising sclk
    always @(posedge dac_sclk) begin
        if (dac_csel === 1'b0) begin
            frame_shift = {frame_shift[qla_pkg::DAC_FRAME_W-2:0], dac_mosi};
            frame_bits++;
            if (frame_bits == qla_pkg::DAC_FRAME_W) begin
                frame_q.push_back(frame_shift);
                frame_bits = 0;
            end
        end
    end

    // --------------------
    // typed compares
    task automatic compare_word(input string name, input logic [qla_pkg::DATA_W-1:0] got,
                                input logic [qla_pkg::DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            error_count++;
            test_bad = 1'b1;
        end else begin
            pass_count++;
        end
    endtask

    task automatic compare_frame(input string name, input logic [qla_pkg::DAC_FRAME_W-1:0] got,
                                 input logic [qla_pkg::DAC_FRAME_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            error_count++;
            test_bad = 1'b1;
        end else begin
            pass_count++;
        end
    endtask

    task automatic compare_amp(input string name, input logic [qla_pkg::NUM_AXES-1:0] got,
                               input logic [qla_pkg::NUM_AXES-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            error_count++;
            test_bad = 1'b1;
        end else begin
            pass_count++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            error_count++;
            test_bad = 1'b1;
        end else begin
            pass_count++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR %s", msg);
        error_count++;
        test_bad = 1'b1;
    endtask

    // --------------------
    // one apb transfer held until pready
    task automatic apb_access(input logic write, input logic [qla_pkg::ADDR_W-1:0] addr,
                              input logic [qla_pkg::DATA_W-1:0] wdata,
                              output logic [qla_pkg::DATA_W-1:0] rdata, output logic err);
        int waited;
        waited = 0;
        @(posedge sysclk);
        psel <= 1'b1;                               // setup phase
        penable <= 1'b0;
        pwrite <= write;
        paddr <= addr;
        pwdata <= wdata;
        @(posedge sysclk);
        penable <= 1'b1;                            // access phase
        @(negedge sysclk);
        while (!pready && waited < TIMEOUT) begin
            @(negedge sysclk);
            waited++;
        end
        rdata = prdata;
        err = pslverr;
        if (!pready) begin
            report_failure($sformatf("no pready within %0d cycles at address %h",
                                     TIMEOUT, addr));
        end
        @(posedge sysclk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic set_feedback(input logic [31:0] axis, input logic [qla_pkg::CUR_W-1:0] value);
        @(posedge sysclk);
        case (axis)
            1: cur_fb1 <= value;
            2: cur_fb2 <= value;
            3: cur_fb3 <= value;
            4: cur_fb4 <= value;
            default: report_failure($sformatf("feedback axis %0d does not exist", axis));
        endcase
    endtask

    task automatic wait_frame(output logic [qla_pkg::DAC_FRAME_W-1:0] frame, output logic ok);
        int waited;
        waited = 0;
        while (frame_q.size() == 0 && waited < TIMEOUT) begin
            @(negedge sysclk);
            waited++;
        end
        ok = (frame_q.size() != 0);
        frame = ok ? frame_q.pop_front() : '0;
    endtask

    // --------------------
    // one vector line
    task automatic run_test(input logic [7:0] op, input logic [31:0] a1,
                            input logic [31:0] a2, input logic [31:0] a3);
        logic [qla_pkg::DATA_W-1:0]     rdata;
        logic                           err;
        logic                           ok;
        logic [qla_pkg::DAC_FRAME_W-1:0] frame;
        logic [3:0]                     axis_code;
        test_count++;
        test_bad = 1'b0;
        case (op)
            "W": begin
                apb_access(1'b1, a1[qla_pkg::ADDR_W-1:0], a2, rdata, err);
                compare_flag("pslverr", err, a3[0]);
            end
            "R": begin
                apb_access(1'b0, a1[qla_pkg::ADDR_W-1:0], '0, rdata, err);
                compare_flag("pslverr", err, a2[0]);
                compare_word("prdata", rdata, a3);
                // power enable also leaves the board as a port
                if (a1[qla_pkg::ADDR_W-1:0] ==
                    {8'h00, qla_pkg::CHAN_BOARD, qla_pkg::OFF_BOARD_PWR}) begin
                    compare_flag("pwr_enable", pwr_enable, a3[0]);
                end
            end
            "F": set_feedback(a1, a2[qla_pkg::CUR_W-1:0]);
            "D": begin
                axis_code = a1[3:0] - 4'd1;         // frame carries axis minus one
                wait_frame(frame, ok);
                if (!ok) begin
                    report_failure($sformatf("no dac frame for axis %0d within %0d cycles",
                                             a1, TIMEOUT));
                end else begin
                    compare_frame("dac_frame", frame, {qla_pkg::DAC_CMD_WRITE_UPDATE,
                                                       axis_code, a2[qla_pkg::CUR_W-1:0]});
                end
            end
            "A": begin
                repeat (a1) @(posedge sysclk);
                @(negedge sysclk);
                compare_amp("amp_en", amp_en, a3[qla_pkg::NUM_AXES-1:0]);
            end
            default: report_failure($sformatf("unknown operation %c in test file", op));
        endcase
        $display("test %0d: %c %h %h %h %s", test_count, op, a1, a2, a3,
                 test_bad ? "failed" : "ok");
    endtask

    // --------------------
    // main sequence
    initial begin
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        rst_n = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        board_id = 4'ha;
        cur_fb1 = qla_pkg::CUR_MID;
        cur_fb2 = qla_pkg::CUR_MID;
        cur_fb3 = qla_pkg::CUR_MID;
        cur_fb4 = qla_pkg::CUR_MID;
        repeat (4) @(posedge sysclk);
        rst_n <= 1'b1;

        // reset values
        @(negedge sysclk);
        test_bad = 1'b0;
        compare_flag("pready", pready, 1'b0);
        compare_flag("pslverr", pslverr, 1'b0);
        compare_flag("dac_csel", dac_csel, 1'b1);
        compare_flag("dac_sclk", dac_sclk, 1'b0);
        compare_flag("pwr_enable", pwr_enable, 1'b0);
        compare_amp("amp_en", amp_en, '0);
        $display("test 0: reset state %s", test_bad ? "failed" : "ok");

        fd = $fopen("testbench/qla_tests.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open testbench/qla_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    op = line.getc(0);
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a1, a2, a3);
                    if (n == 3) begin
                        run_test(op, a1, a2, a3);
                    end else begin
                        report_failure($sformatf("malformed test line: %s", line));
                    end
                end
            end
            $fclose(fd);
        end

        if (frame_q.size() != 0) begin
            report_failure($sformatf("%0d dac frames arrived that no test expected",
                                     frame_q.size()));
        end
        $display("%0d tests, %0d checks passed, %0d failed", test_count, pass_count,
                 error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/qla_top.sv ====
// --------------------
// motor controller register top
// apb bridge, board regs, dac controller, four safety checks
// --------------------

`timescale 1ns/100ps
`default_nettype none

module qla_top (
    input  wire                             sysclk,
    input  wire                             rst_n,
    input  wire [qla_pkg::ADDR_W-1:0]       paddr,
    input  wire                             psel,
    input  wire                             penable,
    input  wire                             pwrite,
    input  wire [qla_pkg::DATA_W-1:0]       pwdata,
    output wire [qla_pkg::DATA_W-1:0]       prdata,
    output wire                             pready,
    output wire                             pslverr,
    input  wire [3:0]                       board_id,
    input  wire [qla_pkg::CUR_W-1:0]        cur_fb1,
    input  wire [qla_pkg::CUR_W-1:0]        cur_fb2,
    input  wire [qla_pkg::CUR_W-1:0]        cur_fb3,
    input  wire [qla_pkg::CUR_W-1:0]        cur_fb4,
    output wire [qla_pkg::NUM_AXES-1:0]     amp_en,
    output wire                             pwr_enable,
    output wire                             dac_sclk,
    output wire                             dac_mosi,
    output wire                             dac_csel
);

    // --------------------
    // shared register bus
    wire                            reg_wen;
    wire [qla_pkg::ADDR_W-1:0]      reg_waddr;
    wire [qla_pkg::ADDR_W-1:0]      reg_raddr;
    wire [qla_pkg::DATA_W-1:0]      reg_wdata;
    wire [qla_pkg::DATA_W-1:0]      reg_rdata_board;
    wire [qla_pkg::DATA_W-1:0]      reg_rdata_dac;

    wire                            safety_clr;
    wire [qla_pkg::NUM_AXES-1:0]    safety_disable;    // bit 0 = axis 1
    wire                            dac_busy;
    wire [qla_pkg::CUR_W-1:0]       cur_cmd1, cur_cmd2, cur_cmd3, cur_cmd4;

    qla_reg_bridge bridge (
        .sysclk(sysclk), .rst_n(rst_n),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_raddr(reg_raddr),
        .reg_wdata(reg_wdata),
        .reg_rdata_board(reg_rdata_board), .reg_rdata_dac(reg_rdata_dac)
    );

    qla_board_regs chan0 (
        .sysclk(sysclk), .rst_n(rst_n),
        .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_raddr(reg_raddr), .reg_rdata_board(reg_rdata_board),
        .board_id(board_id), .safety_disable(safety_disable), .dac_busy(dac_busy),
        .amp_en(amp_en), .pwr_enable(pwr_enable), .safety_clr(safety_clr)
    );

    qla_dac_ctrl dac (
        .sysclk(sysclk), .rst_n(rst_n),
        .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_raddr(reg_raddr), .reg_rdata_dac(reg_rdata_dac),
        .cur_cmd1(cur_cmd1), .cur_cmd2(cur_cmd2),
        .cur_cmd3(cur_cmd3), .cur_cmd4(cur_cmd4),
        .dac_busy(dac_busy),
        .dac_sclk(dac_sclk), .dac_mosi(dac_mosi), .dac_csel(dac_csel)
    );

    // --------------------
    // safety checks, feedback vs command per axis
    qla_safety_check safe1 (
        .sysclk(sysclk), .rst_n(rst_n), .cur_fb(cur_fb1), .cur_cmd(cur_cmd1),
        .safety_clr(safety_clr), .safety_disable(safety_disable[0])
    );

    qla_safety_check safe2 (
        .sysclk(sysclk), .rst_n(rst_n), .cur_fb(cur_fb2), .cur_cmd(cur_cmd2),
        .safety_clr(safety_clr), .safety_disable(safety_disable[1])
    );

    qla_safety_check safe3 (
        .sysclk(sysclk), .rst_n(rst_n), .cur_fb(cur_fb3), .cur_cmd(cur_cmd3),
        .safety_clr(safety_clr), .safety_disable(safety_disable[2])
    );

    qla_safety_check safe4 (
        .sysclk(sysclk), .rst_n(rst_n), .cur_fb(cur_fb4), .cur_cmd(cur_cmd4),
        .safety_clr(safety_clr), .safety_disable(safety_disable[3])
    );

endmodule

`default_nettype wire

// ==== design/qla_safety_check.sv ====
// --------------------
// per-axis overcurrent check
// trips after a run of over-limit cycles, latched until cleared
// --------------------

`timescale 1ns/100ps
`default_nettype none

module qla_safety_check (
    input  logic                        sysclk,
    input  logic                        rst_n,
    input  logic [qla_pkg::CUR_W-1:0]   cur_fb,
    input  logic [qla_pkg::CUR_W-1:0]   cur_cmd,
    input  logic                        safety_clr,
    output logic                        safety_disable
);

    logic [qla_pkg::CUR_W-1:0]          fb_mag;
    logic [qla_pkg::CUR_W-1:0]          cmd_mag;
    logic [qla_pkg::CUR_W+1:0]          limit;     // 2*cmd + margin, no overflow
    logic                               over;
    logic [qla_pkg::SAFETY_CNT_W-1:0]   cnt;

    // magnitudes around midscale
    assign fb_mag = cur_fb[qla_pkg::CUR_W-1] ? (cur_fb - qla_pkg::CUR_MID)
                                             : (qla_pkg::CUR_MID - cur_fb);
    assign cmd_mag = cur_cmd[qla_pkg::CUR_W-1] ? (cur_cmd - qla_pkg::CUR_MID)
                                               : (qla_pkg::CUR_MID - cur_cmd);
    assign limit = {1'b0, cmd_mag, 1'b0} + qla_pkg::SAFETY_MARGIN;
    assign over = {2'b00, fb_mag} > limit;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            cnt <= '0;
            safety_disable <= 1'b0;
        end else if (safety_clr) begin
            cnt <= '0;
            safety_disable <= 1'b0;
        end else begin
            if (!over) begin
                cnt <= '0;                           // run broken
            end else if (cnt != qla_pkg::SAFETY_CNT_W'(qla_pkg::SAFETY_COUNT)) begin
                cnt <= cnt + 1'b1;                   // saturates
            end
            // set on the SAFETY_COUNT-th consecutive hit
            if (over && cnt == qla_pkg::SAFETY_CNT_W'(qla_pkg::SAFETY_COUNT - 1)) begin
                safety_disable <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/qla_dac_ctrl.sv ====
// --------------------
// quad dac controller
// per-axis command registers, pending queue, serial frame output
// --------------------

`timescale 1ns/100ps
`default_nettype none

module qla_dac_ctrl (
    input  logic                        sysclk,
    input  logic                        rst_n,
    input  logic                        reg_wen,
    input  logic [qla_pkg::ADDR_W-1:0]  reg_waddr,
    input  logic [qla_pkg::DATA_W-1:0]  reg_wdata,
    input  logic [qla_pkg::ADDR_W-1:0]  reg_raddr,
    output logic [qla_pkg::DATA_W-1:0]  reg_rdata_dac,
    output logic [qla_pkg::CUR_W-1:0]   cur_cmd1,
    output logic [qla_pkg::CUR_W-1:0]   cur_cmd2,
    output logic [qla_pkg::CUR_W-1:0]   cur_cmd3,
    output logic [qla_pkg::CUR_W-1:0]   cur_cmd4,
    output logic                        dac_busy,
    output logic                        dac_sclk,
    output logic                        dac_mosi,
    output logic                        dac_csel
);

    qla_pkg::dac_state_e state;
    logic [qla_pkg::CUR_W-1:0]       cmd [qla_pkg::NUM_AXES];
    logic [qla_pkg::NUM_AXES-1:0]    pending;
    logic [qla_pkg::NUM_AXES-1:0]    set_mask;
    logic [qla_pkg::NUM_AXES-1:0]    clr_mask;
    logic [qla_pkg::AXIS_W-1:0]      pick;         // lowest pending axis
    logic [qla_pkg::AXIS_W-1:0]      sel;          // axis being sent
    logic [qla_pkg::AXIS_W-1:0]      wr_axis;
    logic [qla_pkg::AXIS_W-1:0]      rd_axis;
    logic                            wr_cmd;
    logic                            rd_cmd;
    logic [qla_pkg::DAC_FRAME_W-1:0] shreg;
    logic [qla_pkg::FRAME_CNT_W-1:0] bit_cnt;
    logic                            gap_cnt;

    // --------------------
    // register decode, channels 1..4 map to axes 0..3
    assign wr_cmd = reg_wen && reg_waddr[7:4] >= 4'd1 &&
                    reg_waddr[7:4] <= qla_pkg::NUM_AXES &&
                    reg_waddr[3:0] == qla_pkg::OFF_DAC_CTRL;
    assign rd_cmd = reg_raddr[7:4] >= 4'd1 && reg_raddr[7:4] <= qla_pkg::NUM_AXES &&
                    reg_raddr[3:0] == qla_pkg::OFF_DAC_CTRL;
    assign wr_axis = reg_waddr[5:4] - 2'd1;
    assign rd_axis = reg_raddr[5:4] - 2'd1;

    assign set_mask = wr_cmd ? (qla_pkg::NUM_AXES'(1) << wr_axis) : '0;
    assign clr_mask = (state == qla_pkg::DAC_LOAD) ? (qla_pkg::NUM_AXES'(1) << sel) : '0;

    always_comb begin
        pick = '0;
        for (int i = qla_pkg::NUM_AXES - 1; i >= 0; i--) begin
            if (pending[i]) pick = qla_pkg::AXIS_W'(i);
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            for (int i = 0; i < qla_pkg::NUM_AXES; i++) cmd[i] <= qla_pkg::CUR_MID;
            pending <= '0;
        end else begin
            if (wr_cmd) cmd[wr_axis] <= reg_wdata[qla_pkg::CUR_W-1:0];
            pending <= (pending & ~clr_mask) | set_mask;    // late write requeues
        end
    end

    always_ff @(posedge sysclk) begin
        reg_rdata_dac <= '0;
        if (rd_cmd) reg_rdata_dac[qla_pkg::CUR_W:0] <= {pending[rd_axis], cmd[rd_axis]};
    end

    assign cur_cmd1 = cmd[0];
    assign cur_cmd2 = cmd[1];
    assign cur_cmd3 = cmd[2];
    assign cur_cmd4 = cmd[3];
    assign dac_busy = (state != qla_pkg::DAC_IDLE) || (|pending);
    assign dac_mosi = shreg[qla_pkg::DAC_FRAME_W-1];     // msb first

    // --------------------
    // serial fsm, sclk = sysclk/2
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state <= qla_pkg::DAC_IDLE;
            dac_csel <= 1'b1;
            dac_sclk <= 1'b0;
            sel <= '0;
            bit_cnt <= '0;
            gap_cnt <= 1'b0;
        end else begin
            case (state)
                qla_pkg::DAC_IDLE: begin
                    if (|pending) begin
                        sel <= pick;
                        state <= qla_pkg::DAC_LOAD;
                    end
                end
                qla_pkg::DAC_LOAD: begin
                    dac_csel <= 1'b0;
                    bit_cnt <= '0;
                    state <= qla_pkg::DAC_SHIFT;
                end
                qla_pkg::DAC_SHIFT: begin
                    dac_sclk <= !dac_sclk;
                    if (dac_sclk) begin                  // falling edge, next bit
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == qla_pkg::FRAME_CNT_W'(qla_pkg::DAC_FRAME_W - 1)) begin
                            dac_csel <= 1'b1;
                            gap_cnt <= 1'b0;
                            state <= qla_pkg::DAC_GAP;
                        end
                    end
                end
                default: begin                           // DAC_GAP, 2 idle cycles
                    gap_cnt <= 1'b1;
                    if (gap_cnt) state <= qla_pkg::DAC_IDLE;
                end
            endcase
        end
    end

    // frame shifter, payload only
    always_ff @(posedge sysclk) begin
        if (state == qla_pkg::DAC_LOAD) begin
            shreg <= {qla_pkg::DAC_CMD_WRITE_UPDATE,
                      {(qla_pkg::DAC_ADDR_W - qla_pkg::AXIS_W){1'b0}}, sel, cmd[sel]};
        end else if (state == qla_pkg::DAC_SHIFT && dac_sclk) begin
            shreg <= shreg << 1;
        end
    end

    a_csel_framed: assert property (@(posedge sysclk) disable iff (!rst_n)
        !dac_csel |-> (state == qla_pkg::DAC_LOAD || state == qla_pkg::DAC_SHIFT));

endmodule

`default_nettype wire

// ==== design/qla_board_regs.sv ====
// --------------------
// channel 0 board registers
// amp enables masked by safety, power enable, safety clear pulse
// --------------------

`timescale 1ns/100ps
`default_nettype none

module qla_board_regs (
    input  logic                            sysclk,
    input  logic                            rst_n,
    input  logic                            reg_wen,
    input  logic [qla_pkg::ADDR_W-1:0]      reg_waddr,
    input  logic [qla_pkg::DATA_W-1:0]      reg_wdata,
    input  logic [qla_pkg::ADDR_W-1:0]      reg_raddr,
    output logic [qla_pkg::DATA_W-1:0]      reg_rdata_board,
    input  logic [3:0]                      board_id,
    input  logic [qla_pkg::NUM_AXES-1:0]    safety_disable,
    input  logic                            dac_busy,
    output logic [qla_pkg::NUM_AXES-1:0]    amp_en,
    output logic                            pwr_enable,
    output logic                            safety_clr
);

    logic [qla_pkg::NUM_AXES-1:0] amp_req;     // host enable request
    logic wr_chan0;
    logic wr_status;
    logic wr_pwr;

    assign wr_chan0 = reg_wen && (reg_waddr[7:4] == qla_pkg::CHAN_BOARD);
    assign wr_status = wr_chan0 && (reg_waddr[3:0] == qla_pkg::OFF_BOARD_STATUS);
    assign wr_pwr = wr_chan0 && (reg_waddr[3:0] == qla_pkg::OFF_BOARD_PWR);

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            amp_req <= '0;
            amp_en <= '0;
            pwr_enable <= 1'b0;
            safety_clr <= 1'b0;
        end else begin
            safety_clr <= wr_status && reg_wdata[8];   // one-cycle pulse
            if (wr_status) begin
                amp_req <= reg_wdata[qla_pkg::NUM_AXES-1:0];
            end
            if (wr_pwr) begin
                pwr_enable <= reg_wdata[0];
            end
            amp_en <= amp_req & ~safety_disable;     // tripped axes held off
        end
    end

    // --------------------
    // read mux, one cycle behind raddr
    always_ff @(posedge sysclk) begin
        reg_rdata_board <= '0;
        if (reg_raddr[7:4] == qla_pkg::CHAN_BOARD) begin
            if (reg_raddr[3:0] == qla_pkg::OFF_BOARD_STATUS) begin
                reg_rdata_board[3:0] <= amp_req;
                reg_rdata_board[7:4] <= safety_disable;
                reg_rdata_board[11:8] <= board_id;
                reg_rdata_board[12] <= dac_busy;
            end else if (reg_raddr[3:0] == qla_pkg::OFF_BOARD_PWR) begin
                reg_rdata_board[0] <= pwr_enable;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/qla_reg_bridge.sv ====
// --------------------
// apb slave to shared register bus
// decodes the map, strobes writes, returns peer read data
// --------------------

`timescale 1ns/100ps
`default_nettype none

module qla_reg_bridge (
    input  logic                        sysclk,
    input  logic                        rst_n,
    input  logic [qla_pkg::ADDR_W-1:0]  paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [qla_pkg::DATA_W-1:0]  pwdata,
    output logic [qla_pkg::DATA_W-1:0]  prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic                        reg_wen,
    output logic [qla_pkg::ADDR_W-1:0]  reg_waddr,
    output logic [qla_pkg::ADDR_W-1:0]  reg_raddr,
    output logic [qla_pkg::DATA_W-1:0]  reg_wdata,
    input  logic [qla_pkg::DATA_W-1:0]  reg_rdata_board,
    input  logic [qla_pkg::DATA_W-1:0]  reg_rdata_dac
);

    qla_pkg::bridge_state_e state;
    logic [3:0] chan;
    logic [3:0] off;
    logic       mapped;
    logic       sel_board;

    // host holds address and data until pready, so pass straight through
    assign reg_raddr = paddr;
    assign reg_waddr = paddr;
    assign reg_wdata = pwdata;

    // --------------------
    // address decode
    assign chan = paddr[7:4];
    assign off = paddr[3:0];
    assign sel_board = (chan == qla_pkg::CHAN_BOARD);
    assign mapped = (paddr[qla_pkg::ADDR_W-1:8] == '0) &&
                    ((sel_board && (off == qla_pkg::OFF_BOARD_STATUS ||
                                    off == qla_pkg::OFF_BOARD_PWR)) ||
                     (chan >= 4'd1 && chan <= qla_pkg::NUM_AXES &&
                      off == qla_pkg::OFF_DAC_CTRL));

    // --------------------
    // apb fsm
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state <= qla_pkg::BR_IDLE;
            pready <= 1'b0;
            pslverr <= 1'b0;
            reg_wen <= 1'b0;
        end else begin
            reg_wen <= 1'b0;                            // single-cycle strobe
            case (state)
                qla_pkg::BR_IDLE: begin
                    if (psel && !penable) begin         // setup phase
                        if (pwrite) begin
                            reg_wen <= mapped;          // unmapped write dropped
                            pready <= 1'b1;             // no wait state
                            pslverr <= !mapped;
                            state <= qla_pkg::BR_DONE;
                        end else begin
                            state <= qla_pkg::BR_READ_WAIT;
                        end
                    end
                end
                qla_pkg::BR_READ_WAIT: begin
                    pready <= 1'b1;
                    pslverr <= !mapped;
                    state <= qla_pkg::BR_DONE;
                end
                default: begin                          // BR_DONE
                    pready <= 1'b0;
                    pslverr <= 1'b0;
                    state <= qla_pkg::BR_IDLE;
                end
            endcase
        end
    end

    // peer data is already registered by the wait state
    always_ff @(posedge sysclk) begin
        if (state == qla_pkg::BR_READ_WAIT) begin
            prdata <= !mapped ? '0 : (sel_board ? reg_rdata_board : reg_rdata_dac);
        end
    end

    // host must still hold the access phase when the slave answers
    a_pready_in_access: assert property (@(posedge sysclk) disable iff (!rst_n)
        pready |-> (psel && penable));

endmodule

`default_nettype wire

// ==== design/qla_pkg.sv ====
// --------------------
// qla shared definitions
// register address map, field widths, safety limits and FSM encodings
// --------------------

`default_nettype none

package qla_pkg;

    // register bus
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // currents, offset binary around midscale
    localparam int CUR_W = 16;
    localparam logic [CUR_W-1:0] CUR_MID = 16'h8000;

    localparam int NUM_AXES = 4;
    localparam int AXIS_W = 2;                      // axis index 0..3

    // address map: chan = addr[7:4], offset = addr[3:0]
    localparam logic [3:0] CHAN_BOARD = 4'd0;       // axes live in channels 1..4
    localparam logic [3:0] OFF_BOARD_STATUS = 4'd0;
    localparam logic [3:0] OFF_BOARD_PWR = 4'd1;
    localparam logic [3:0] OFF_DAC_CTRL = 4'd1;

    // quad dac serial frame: cmd | addr | value
    localparam int DAC_FRAME_W = 24;
    localparam int DAC_ADDR_W = 4;
    localparam int FRAME_CNT_W = $clog2(DAC_FRAME_W);
    localparam logic [3:0] DAC_CMD_WRITE_UPDATE = 4'b0011;

    // overcurrent test
    localparam logic [CUR_W-1:0] SAFETY_MARGIN = 16'h0100;
    localparam int SAFETY_COUNT = 8;
    localparam int SAFETY_CNT_W = $clog2(SAFETY_COUNT + 1);

    typedef enum logic [1:0] {
        BR_IDLE,
        BR_READ_WAIT,   // read wait state
        BR_DONE         // pready cycle
    } bridge_state_e;

    typedef enum logic [1:0] {
        DAC_IDLE,
        DAC_LOAD,
        DAC_SHIFT,
        DAC_GAP
    } dac_state_e;

endpackage

`default_nettype wire
